//--- verilog/trace_cfg_pkg.sv
/*
  Sizing constants for the pipeline trace unit.
  Shared by the dispatcher, the tracking slots and the drain.
*/
package trace_cfg_pkg;

  //////////////////////////////
  // Slot array sizing
  //////////////////////////////
  // Number of in-flight instructions that can be tracked at once
  localparam int NUM_SLOTS = 8;

  // Slot index, wide enough for NUM_SLOTS entries
  localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);
  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

  //////////////////////////////
  // Output flow control
  //////////////////////////////
  // Credits held by the drain right after reset
  localparam int TRACE_CREDITS = 4;
  // Credit counter must also hold the full count
  localparam int CREDIT_W = $clog2(TRACE_CREDITS + 1);

  //////////////////////////////
  // Counter widths
  //////////////////////////////
  localparam int CYCLE_W = 16;  // free running cycle counter and stamps
  localparam int STALL_W = 4;   // per stage stall counters, saturating
  localparam int DROP_W  = 16;  // untraced instruction counter

endpackage

//--- verilog/rv_trace_pkg.sv
/*
  RISC-V instruction views and trace record types.
  The union gives R-type and I-type views of one instruction word,
  the structs carry fetch events in and finished trace records out.
*/
package rv_trace_pkg;

  //////////////////////////////
  // Major opcodes of interest
  //////////////////////////////
  localparam logic [6:0] OPC_REG  = 7'b0110011;  // register-register ALU
  localparam logic [6:0] OPC_IMM  = 7'b0010011;  // register-immediate ALU
  localparam logic [6:0] OPC_LOAD = 7'b0000011;  // loads, also I-format

  //////////////////////////////
  // Instruction word views
  //////////////////////////////
  // R-type layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  // I-type layout, imm12 takes the funct7 and rs2 bits
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  // Same 32 bits, decoded either way
  typedef union packed {
    rv_r_t r;
    rv_i_t i;
  } rv_instr_u;

  //////////////////////////////
  // Enums
  //////////////////////////////
  typedef enum logic [1:0] {
    CLS_REG,
    CLS_IMM,
    CLS_OTHER
  } instr_class_t;

  // Where a tracked instruction currently sits
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK,
    ST_DONE
  } stage_t;

  //////////////////////////////
  // Fetch event and trace record
  //////////////////////////////
  typedef struct packed {
    logic [31:0] pc;
    rv_instr_u   instr;
  } fetch_evt_t;

  typedef struct packed {
    logic [31:0]                          pc;
    rv_instr_u                            instr;
    instr_class_t                         cls;
    logic [4:0]                           rd;
    logic [4:0]                           rs1;
    logic [31:0]                          operand;  // rs2 or sign-extended imm12
    logic [trace_cfg_pkg::CYCLE_W-1:0]    fetch_cycle;
    logic [trace_cfg_pkg::CYCLE_W-1:0]    retire_cycle;
    logic [trace_cfg_pkg::STALL_W-1:0]    fetch_stalls;
    logic [trace_cfg_pkg::STALL_W-1:0]    decode_stalls;
  } trace_rec_t;

endpackage

//--- verilog/trace_dispatch.sv
/*
  Front end of the trace unit.
  Runs the cycle counter, decodes each fetched word into a partial
  trace record and hands it to the next slot in round-robin order.
  Fetches that find that slot busy are counted as drops.
*/
`timescale 1ns/10ps

module trace_dispatch (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 fetch_valid,
  input  rv_trace_pkg::fetch_evt_t             fetch_evt,
  input  logic [trace_cfg_pkg::NUM_SLOTS-1:0]  slot_free,
  output logic [trace_cfg_pkg::NUM_SLOTS-1:0]  load,
  output rv_trace_pkg::trace_rec_t             load_rec,
  output logic [trace_cfg_pkg::CYCLE_W-1:0]    cycle,
  output logic [trace_cfg_pkg::DROP_W-1:0]     drop_count
);

  import trace_cfg_pkg::*;
  import rv_trace_pkg::*;

  slot_idx_t alloc_ptr;
  logic      alloc_ok;
  rv_instr_u word;

  //////////////////////////////
  // Cycle counter
  //////////////////////////////
  // Zero after reset and one step per edge
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cycle <= '0;
    else
      cycle <= cycle + 1'b1;
  end

  //////////////////////////////
  // Field decode
  //////////////////////////////
  // Stamps and stall counts stay zero until the slot fills them
  always_comb begin
    word     = fetch_evt.instr;
    load_rec = '0;
    load_rec.pc    = fetch_evt.pc;
    load_rec.instr = word;
    // Register fields sit at the same bits in both views
    load_rec.rd    = word.r.rd;
    load_rec.rs1   = word.r.rs1;
    case (word.r.opcode)
      OPC_REG: begin
        load_rec.cls     = CLS_REG;
        // Second source register number zero-extended
        load_rec.operand = {27'd0, word.r.rs2};
      end
      OPC_IMM, OPC_LOAD: begin
        load_rec.cls     = CLS_IMM;
        load_rec.operand = {{20{word.i.imm12[11]}}, word.i.imm12};
      end
      default: begin
        load_rec.cls     = CLS_OTHER;
        load_rec.operand = '0;
      end
    endcase
  end

  //////////////////////////////
  // Slot allocation
  //////////////////////////////
  // Only the pointed slot is ever considered
  assign alloc_ok = fetch_valid && slot_free[alloc_ptr];

  // One-hot load strobe to the pointed slot
  always_comb begin
    load            = '0;
    load[alloc_ptr] = alloc_ok;
  end

  // Pointer moves only on a successful load and in the drain's order
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      alloc_ptr <= '0;
    else if (alloc_ok) begin
      if (alloc_ptr == slot_idx_t'(NUM_SLOTS - 1))
        alloc_ptr <= '0;
      else
        alloc_ptr <= alloc_ptr + 1'b1;
    end
  end

  // Busy slot under the pointer means the fetch goes untraced
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      drop_count <= '0;
    else if (fetch_valid && !slot_free[alloc_ptr])
      drop_count <= drop_count + 1'b1;
  end

endmodule

//--- verilog/trace_slot.sv
/*
  One tracking slot of the trace unit.
  Follows a single instruction from fetch to writeback, counting
  fetch and decode stalls, and holds the finished record until taken.
*/
`timescale 1ns/10ps

module trace_slot (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load,
  input  rv_trace_pkg::trace_rec_t           load_rec,
  input  logic                               stall,
  input  logic [trace_cfg_pkg::CYCLE_W-1:0]  cycle,
  input  logic                               take,
  output logic                               free,
  output logic                               done,
  output rv_trace_pkg::trace_rec_t           rec
);

  import rv_trace_pkg::*;

  stage_t     state;
  stage_t     state_nxt;
  trace_rec_t rec_q;

  //////////////////////////////
  // Stage tracking FSM
  //////////////////////////////
  // Fetch and decode hold on stall, later stages always advance
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:      if (load) state_nxt = ST_FETCH;
      ST_FETCH:     if (!stall) state_nxt = ST_DECODE;
      ST_DECODE:    if (!stall) state_nxt = ST_EXECUTE;
      ST_EXECUTE:   state_nxt = ST_MEMORY;
      ST_MEMORY:    state_nxt = ST_WRITEBACK;
      ST_WRITEBACK: state_nxt = ST_DONE;
      ST_DONE:      if (take) state_nxt = ST_IDLE;
      default:      state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  //////////////////////////////
  // Record contents
  //////////////////////////////
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (load) begin
          // Fresh record, fetch stamped with the current cycle
          rec_q               <= load_rec;
          rec_q.fetch_cycle   <= cycle;
          rec_q.retire_cycle  <= '0;
          rec_q.fetch_stalls  <= '0;
          rec_q.decode_stalls <= '0;
        end
      end
      ST_FETCH: begin
        // Saturate at all ones
        if (stall && rec_q.fetch_stalls != '1)
          rec_q.fetch_stalls <= rec_q.fetch_stalls + 1'b1;
      end
      ST_DECODE: begin
        if (stall && rec_q.decode_stalls != '1)
          rec_q.decode_stalls <= rec_q.decode_stalls + 1'b1;
      end
      ST_WRITEBACK: begin
        // Edge leaving writeback is the retire point
        rec_q.retire_cycle <= cycle;
      end
      default: begin
        rec_q <= rec_q;
      end
    endcase
  end

  //////////////////////////////
  // Status to dispatcher and drain
  //////////////////////////////
  assign free = (state == ST_IDLE);
  assign done = (state == ST_DONE);
  assign rec  = rec_q;

endmodule

//--- verilog/trace_drain.sv
/*
  Output stage of the trace unit.
  Walks the slots in allocation order and sends each finished record
  once, as long as the consumer has credit left.
*/
`timescale 1ns/10ps

module trace_drain (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [trace_cfg_pkg::NUM_SLOTS-1:0]  slot_done,
  input  rv_trace_pkg::trace_rec_t             slot_recs [trace_cfg_pkg::NUM_SLOTS],
  input  logic                                 trace_credit,
  output logic [trace_cfg_pkg::NUM_SLOTS-1:0]  take,
  output logic                                 trace_valid,
  output rv_trace_pkg::trace_rec_t             trace_rec
);

  import trace_cfg_pkg::*;

  slot_idx_t           drain_ptr;
  logic [CREDIT_W-1:0] credit_cnt;
  logic                send;

  //////////////////////////////
  // Send decision
  //////////////////////////////
  // Program order kept by looking only at the pointed slot
  assign send = slot_done[drain_ptr] && (credit_cnt != '0);

  // Take frees the slot at the same edge the record is registered
  always_comb begin
    take            = '0;
    take[drain_ptr] = send;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      drain_ptr <= '0;
    else if (send) begin
      if (drain_ptr == slot_idx_t'(NUM_SLOTS - 1))
        drain_ptr <= '0;
      else
        drain_ptr <= drain_ptr + 1'b1;
    end
  end

  //////////////////////////////
  // Credit counter
  //////////////////////////////
  // Return and spend in one cycle leave the count unchanged
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      credit_cnt <= CREDIT_W'(TRACE_CREDITS);
    else begin
      case ({trace_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////
  // Valid pulses for one cycle per record
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      trace_valid <= 1'b0;
    else
      trace_valid <= send;
  end

  // Payload only loads on a send
  always_ff @(posedge clk) begin
    if (send)
      trace_rec <= slot_recs[drain_ptr];
  end

endmodule

//--- verilog/pipe_trace_top.sv
/*
  Top level of the pipeline trace unit.
  Takes fetch events and stall from the CPU and emits one trace
  record per retired instruction under credit flow control.
*/
`timescale 1ns/10ps

module pipe_trace_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              fetch_valid,
  input  rv_trace_pkg::fetch_evt_t          fetch_evt,
  input  logic                              stall,
  input  logic                              trace_credit,
  output logic                              trace_valid,
  output rv_trace_pkg::trace_rec_t          trace_rec,
  output logic [trace_cfg_pkg::DROP_W-1:0]  drop_count
);

  import trace_cfg_pkg::*;
  import rv_trace_pkg::*;

  // Dispatcher to slots
  logic [CYCLE_W-1:0]   cycle;
  logic [NUM_SLOTS-1:0] load;
  trace_rec_t           load_rec;

  // Slots to dispatcher and drain
  logic [NUM_SLOTS-1:0] slot_free;
  logic [NUM_SLOTS-1:0] slot_done;
  trace_rec_t           slot_recs [NUM_SLOTS];

  // Drain back to slots
  logic [NUM_SLOTS-1:0] take;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////
  trace_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_valid(fetch_valid),
    .fetch_evt  (fetch_evt),
    .slot_free  (slot_free),
    .load       (load),
    .load_rec   (load_rec),
    .cycle      (cycle),
    .drop_count (drop_count)
  );

  //////////////////////////////
  // Tracking slots
  //////////////////////////////
  for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
    trace_slot u_slot (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load[s]),
      .load_rec(load_rec),
      .stall   (stall),
      .cycle   (cycle),
      .take    (take[s]),
      .free    (slot_free[s]),
      .done    (slot_done[s]),
      .rec     (slot_recs[s])
    );
  end

  //////////////////////////////
  // Drain
  //////////////////////////////
  trace_drain u_drain (
    .clk         (clk),
    .rst_n       (rst_n),
    .slot_done   (slot_done),
    .slot_recs   (slot_recs),
    .trace_credit(trace_credit),
    .take        (take),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec)
  );

endmodule

//--- bench/trace_checker.sv
/*
  Scoreboard for the pipeline trace unit.
  Follows slot allocation, stage timing and credits from the DUT ports,
  builds each expected record and compares it when trace_valid arrives.
*/
`timescale 1ns/10ps

module trace_checker (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              fetch_valid,
  input  rv_trace_pkg::fetch_evt_t          fetch_evt,
  input  logic                              stall,
  input  logic                              trace_credit,
  input  logic                              trace_valid,
  input  rv_trace_pkg::trace_rec_t          trace_rec,
  input  logic [trace_cfg_pkg::DROP_W-1:0]  drop_count,
  output int                                error_count,
  output int                                compare_count,
  output logic                              model_idle
);

  import trace_cfg_pkg::*;
  import rv_trace_pkg::*;

  // Model of every tracking slot
  stage_t             m_state [NUM_SLOTS];
  fetch_evt_t         m_evt   [NUM_SLOTS];
  logic [CYCLE_W-1:0] m_fcyc  [NUM_SLOTS];
  logic [CYCLE_W-1:0] m_rcyc  [NUM_SLOTS];
  logic [STALL_W-1:0] m_fst   [NUM_SLOTS];
  logic [STALL_W-1:0] m_dst   [NUM_SLOTS];

  int                 alloc_ptr;
  int                 drain_ptr;
  int                 credits;
  int                 drops;
  int                 returned;
  int                 received = 0;
  int                 errors = 0;
  int                 compares = 0;
  logic [CYCLE_W-1:0] cyc;
  trace_rec_t         exp_q [$];

  assign error_count   = errors;
  assign compare_count = compares;

  //////////////////////////////
  // Reference record
  //////////////////////////////
  // Fields straight from the RISC-V bit positions
  function automatic trace_rec_t expected_rec(input fetch_evt_t evt,
      input logic [CYCLE_W-1:0] fcyc, input logic [CYCLE_W-1:0] rcyc,
      input logic [STALL_W-1:0] fst, input logic [STALL_W-1:0] dst);
    trace_rec_t  r;
    logic [31:0] w;
    w     = evt.instr;
    r.pc  = evt.pc;
    r.instr = evt.instr;
    r.rd  = w[11:7];
    r.rs1 = w[19:15];
    case (w[6:0])
      7'b0110011: begin
        r.cls     = CLS_REG;
        r.operand = {27'd0, w[24:20]};
      end
      7'b0010011, 7'b0000011: begin
        // Immediate sign comes from bit 31
        r.cls     = CLS_IMM;
        r.operand = {{20{w[31]}}, w[31:20]};
      end
      default: begin
        r.cls     = CLS_OTHER;
        r.operand = 32'd0;
      end
    endcase
    r.fetch_cycle   = fcyc;
    r.retire_cycle  = rcyc;
    r.fetch_stalls  = fst;
    r.decode_stalls = dst;
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("[FAIL] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
    end
  endtask

  //////////////////////////////
  // Slot and credit model
  //////////////////////////////
  // All decisions use the state from before the edge
  always @(posedge clk or negedge rst_n) begin : model_step
    int   s;
    logic send;
    logic load_ok;
    if (!rst_n) begin
      for (s = 0; s < NUM_SLOTS; s++)
        m_state[s] = ST_IDLE;
      alloc_ptr = 0;
      drain_ptr = 0;
      credits   = TRACE_CREDITS;
      drops     = 0;
      returned  = 0;
      cyc       = '0;
      exp_q.delete();
    end else begin
      send    = (m_state[drain_ptr] == ST_DONE) && (credits > 0);
      load_ok = fetch_valid && (m_state[alloc_ptr] == ST_IDLE);
      for (s = 0; s < NUM_SLOTS; s++) begin
        case (m_state[s])
          ST_FETCH: begin
            if (!stall)
              m_state[s] = ST_DECODE;
            else if (m_fst[s] != '1)
              m_fst[s] = m_fst[s] + 1'b1;
          end
          ST_DECODE: begin
            if (!stall)
              m_state[s] = ST_EXECUTE;
            else if (m_dst[s] != '1)
              m_dst[s] = m_dst[s] + 1'b1;
          end
          ST_EXECUTE: m_state[s] = ST_MEMORY;
          ST_MEMORY:  m_state[s] = ST_WRITEBACK;
          ST_WRITEBACK: begin
            m_rcyc[s]  = cyc;
            m_state[s] = ST_DONE;
          end
          default: ;
        endcase
      end
      // Record leaves the slot, shows on trace_valid after this edge
      if (send) begin
        exp_q.push_back(expected_rec(m_evt[drain_ptr], m_fcyc[drain_ptr],
                                     m_rcyc[drain_ptr], m_fst[drain_ptr], m_dst[drain_ptr]));
        m_state[drain_ptr] = ST_IDLE;
        drain_ptr = (drain_ptr + 1) % NUM_SLOTS;
        credits--;
      end
      if (trace_credit) begin
        credits++;
        returned++;
      end
      if (load_ok) begin
        m_state[alloc_ptr] = ST_FETCH;
        m_evt[alloc_ptr]   = fetch_evt;
        m_fcyc[alloc_ptr]  = cyc;
        m_fst[alloc_ptr]   = '0;
        m_dst[alloc_ptr]   = '0;
        alloc_ptr = (alloc_ptr + 1) % NUM_SLOTS;
      end else if (fetch_valid) begin
        drops++;
      end
      cyc = cyc + 1'b1;
    end
  end

  //////////////////////////////
  // Output comparison
  //////////////////////////////
  // Falling edge, DUT outputs settled
  always @(negedge clk) begin : compare
    trace_rec_t exp_r;
    int         s;
    logic       busy;
    if (rst_n) begin
      check_field("drop_count", 32'(drops), 32'(drop_count));
      if (trace_valid === 1'b1) begin
        received++;
        if (received - returned > TRACE_CREDITS) begin
          errors++;
          $display("Credit overrun at %0t ns: %0d records sent without credit back",
                   $time, received - returned);
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("Record at %0t ns arrived when none was due", $time);
        end else begin
          exp_r = exp_q.pop_front();
          compares++;
          check_field("pc", exp_r.pc, trace_rec.pc);
          check_field("instr", exp_r.instr, trace_rec.instr);
          check_field("cls", 32'(exp_r.cls), 32'(trace_rec.cls));
          check_field("rd", 32'(exp_r.rd), 32'(trace_rec.rd));
          check_field("rs1", 32'(exp_r.rs1), 32'(trace_rec.rs1));
          check_field("operand", exp_r.operand, trace_rec.operand);
          check_field("fetch_cycle", 32'(exp_r.fetch_cycle), 32'(trace_rec.fetch_cycle));
          check_field("retire_cycle", 32'(exp_r.retire_cycle), 32'(trace_rec.retire_cycle));
          check_field("fetch_stalls", 32'(exp_r.fetch_stalls), 32'(trace_rec.fetch_stalls));
          check_field("decode_stalls", 32'(exp_r.decode_stalls),
                      32'(trace_rec.decode_stalls));
        end
      end else if (trace_valid !== 1'b0) begin
        errors++;
        $display("trace_valid is unknown at %0t ns", $time);
      end
      // Idle once every slot is empty and nothing is owed
      busy = (exp_q.size() != 0);
      for (s = 0; s < NUM_SLOTS; s++)
        if (m_state[s] != ST_IDLE)
          busy = 1'b1;
      model_idle = !busy;
    end else begin
      model_idle = 1'b0;
    end
  end

endmodule

//--- bench/trace_tb.sv
/*
  Testbench for the pipeline trace unit.
  Runs a credit hold phase, a spaced stall-free phase and a random stall
  phase, and returns credits like a slow consumer. trace_checker compares.
*/
`timescale 1ns/10ps

module trace_tb;

  import trace_cfg_pkg::*;
  import rv_trace_pkg::*;

  // Fetches per phase
  localparam int HOLD_FETCHES   = 16;
  localparam int SPACED_FETCHES = 24;
  localparam int RANDOM_FETCHES = 60;
  localparam int TOTAL_FETCHES  = HOLD_FETCHES + SPACED_FETCHES + RANDOM_FETCHES;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              fetch_valid;
  fetch_evt_t        fetch_evt;
  logic              stall;
  logic              trace_credit = 1'b0;
  logic              trace_valid;
  trace_rec_t        trace_rec;
  logic [DROP_W-1:0] drop_count;

  logic [31:0] stim_seed   = 32'hf5f9;
  logic [31:0] credit_seed = 32'hf5f9;
  logic        hold_credits = 1'b1;
  int          tb_cycle = 0;
  int          rec_count = 0;
  int          bench_errors = 0;
  int          checker_errors;
  int          compare_count;
  logic        model_idle;
  int          credit_due [$];

  always #10 clk = ~clk;

  pipe_trace_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_evt   (fetch_evt),
    .stall       (stall),
    .trace_credit(trace_credit),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec),
    .drop_count  (drop_count)
  );

  trace_checker scoreboard (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_valid  (fetch_valid),
    .fetch_evt    (fetch_evt),
    .stall        (stall),
    .trace_credit (trace_credit),
    .trace_valid  (trace_valid),
    .trace_rec    (trace_rec),
    .drop_count   (drop_count),
    .error_count  (checker_errors),
    .compare_count(compare_count),
    .model_idle   (model_idle)
  );

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Opcode mix: R-type, ALU immediate, load, or branch/LUI
  function automatic fetch_evt_t make_fetch(input logic [31:0] pc_r, input logic [31:0] w_r);
    fetch_evt_t evt;
    logic [6:0] opc;
    case (pc_r[29:28])
      2'd0:    opc = 7'b0110011;
      2'd1:    opc = 7'b0010011;
      2'd2:    opc = 7'b0000011;
      default: opc = pc_r[27] ? 7'b1100011 : 7'b0110111;
    endcase
    evt.pc    = {pc_r[31:2], 2'b00};
    evt.instr = {w_r[31:7], opc};
    return evt;
  endfunction

  // One falling edge; fetch only if stall was low at the last edge
  task automatic step(input logic want_fetch, input logic stall_val, output logic got);
    logic [31:0] pc_r;
    @(negedge clk);
    got         = want_fetch && !stall;
    stall       = stall_val;
    fetch_valid = got;
    if (got) begin
      stim_seed = lcg_next(stim_seed);
      pc_r      = stim_seed;
      stim_seed = lcg_next(stim_seed);
      fetch_evt = make_fetch(pc_r, stim_seed);
    end
  endtask

  // Release stall, then block until every traced record is out
  task automatic wait_for_drain();
    logic got;
    step(1'b0, 1'b0, got);
    step(1'b0, 1'b0, got);
    #1;
    wait (model_idle === 1'b1);
    #1;
  endtask

  //////////////////////////////
  // Consumer credit return
  //////////////////////////////
  // Each record owes one credit, paid 2 to 5 cycles later
  always @(negedge clk) begin : credit_return
    int k;
    int hit;
    if (rst_n) begin
      tb_cycle++;
      if (trace_valid === 1'b1) begin
        rec_count++;
        credit_seed = lcg_next(credit_seed);
        credit_due.push_back(tb_cycle + 2 + int'(credit_seed[17:16]));
      end
      hit = -1;
      if (!hold_credits)
        for (k = 0; k < credit_due.size(); k++)
          if (hit < 0 && credit_due[k] <= tb_cycle)
            hit = k;
      if (hit >= 0) begin
        credit_due.delete(hit);
        trace_credit = 1'b1;
      end else begin
        trace_credit = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin : stimulus
    int   n;
    logic got;
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_evt   = '0;
    stall       = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Credits held: 4 records out, 12 traced, the rest dropped
    for (n = 0; n < HOLD_FETCHES; n++) begin
      step(1'b1, 1'b0, got);
      repeat (7) step(1'b0, 1'b0, got);
    end
    repeat (20) step(1'b0, 1'b0, got);
    if (rec_count != TRACE_CREDITS) begin
      bench_errors++;
      $display("[FAIL] %0t ns: trace_valid count expected %0d, got %0d",
               $time, TRACE_CREDITS, rec_count);
    end
    if (drop_count != DROP_W'(HOLD_FETCHES - NUM_SLOTS - TRACE_CREDITS)) begin
      bench_errors++;
      $display("[FAIL] %0t ns: drop_count expected %0d, got %0d",
               $time, HOLD_FETCHES - NUM_SLOTS - TRACE_CREDITS, drop_count);
    end
    @(posedge clk);
    hold_credits = 1'b0;
    wait_for_drain();
    if (rec_count != NUM_SLOTS + TRACE_CREDITS) begin
      bench_errors++;
      $display("[FAIL] %0t ns: trace_valid count expected %0d, got %0d",
               $time, NUM_SLOTS + TRACE_CREDITS, rec_count);
    end

    // No stalls, one fetch every other cycle
    for (n = 0; n < SPACED_FETCHES; n++) begin
      step(1'b1, 1'b0, got);
      step(1'b0, 1'b0, got);
    end
    wait_for_drain();

    // Random stalls, fetch rate about 3 in 4
    n = 0;
    while (n < RANDOM_FETCHES) begin
      stim_seed = lcg_next(stim_seed);
      step(stim_seed[20:19] != 2'b00, stim_seed[23:22] == 2'b00, got);
      if (got)
        n++;
    end
    wait_for_drain();

    if (compare_count == 0) begin
      bench_errors++;
      $display("No trace records were compared");
    end
    $display("Records compared: %0d, checker errors: %0d, bench errors: %0d",
             compare_count, checker_errors, bench_errors);
    if (checker_errors == 0 && bench_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // 40 cycles per planned fetch
  initial begin : watchdog
    #(TOTAL_FETCHES * 40 * 20);
    $display("Timeout: run did not finish within %0d cycles", TOTAL_FETCHES * 40);
    $display("Errors found");
    $finish;
  end

endmodule

//--- sources.f
verilog/trace_cfg_pkg.sv
verilog/rv_trace_pkg.sv
verilog/trace_dispatch.sv
verilog/trace_slot.sv
verilog/trace_drain.sv
verilog/pipe_trace_top.sv
bench/trace_checker.sv
bench/trace_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the trace unit and its testbench with Verilator, run, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f sources.f --top-module trace_tb \
  -Mdir obj_dir -o trace_sim

./obj_dir/trace_sim > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
